// File: list.f
soc_pkg.sv
axi2apb_bridge.sv
apb_mux.sv
led_driver.sv
uart_tx.sv
int_controller.sv
periph_top.sv
tb_periph_top.sv

// File: run.sh
#!/bin/sh
# verilator build and run of the peripheral testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log

# compile to a binary under obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f list.f --top-module tb_periph_top -o tb_periph_top
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

# run and keep the transcript
./obj_dir/tb_periph_top > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

# verdict comes from the log
if grep -q "TEST FAILED" "$LOG"; then
	exit 1
fi
exit 0

// File: tb_periph_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_periph_top;
	import soc_pkg::*;

	localparam int CLKS_PER_BIT = 16;
	// bus wait limit in cycles
	localparam int TIMEOUT = 100;

	logic                  clk;
	logic                  rst_n;
	addr_t                 awaddr;
	logic                  awvalid;
	logic                  awready;
	data_t                 wdata;
	logic                  wvalid;
	logic                  wready;
	resp_e                 bresp;
	logic                  bvalid;
	logic                  bready;
	addr_t                 araddr;
	logic                  arvalid;
	logic                  arready;
	data_t                 rdata;
	resp_e                 rresp;
	logic                  rvalid;
	logic                  rready;
	logic [IRQ_W-1:0]      irq_src;
	logic [LED_W-1:0]      led;
	logic                  tx;
	logic                  irq;

	int errors;
	int checks;
	int seed;

	periph_top #(
		.CLKS_PER_BIT	(CLKS_PER_BIT	)
	) dut_i (
		.clk		(clk		),
		.rst_n		(rst_n		),
		.awaddr		(awaddr		),
		.awvalid	(awvalid	),
		.awready	(awready	),
		.wdata		(wdata		),
		.wvalid		(wvalid		),
		.wready		(wready		),
		.bresp		(bresp		),
		.bvalid		(bvalid		),
		.bready		(bready		),
		.araddr		(araddr		),
		.arvalid	(arvalid	),
		.arready	(arready	),
		.rdata		(rdata		),
		.rresp		(rresp		),
		.rvalid		(rvalid		),
		.rready		(rready		),
		.irq_src	(irq_src	),
		.led		(led		),
		.tx			(tx			),
		.irq		(irq		)
	);

	// 8 ns period
	always #4 clk = ~clk;

	// full bus address from slot and register offset
	function automatic addr_t reg_addr(input logic [3:0] slot, input logic [11:0] off);
		return APB_BASE | {16'h0, slot, off};
	endfunction

	task automatic check_eq(input string test, input string what,
			input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Error %s %s: expected 0x%0h, actual 0x%0h", test, what, exp, act);
		end
	endtask

	task automatic report_timeout(input string test, input string what);
		errors++;
		$display("%s: timed out waiting for %s", test, what);
	endtask

	// single-beat write with aw and w offered together
	task automatic axi_write(input string test, input addr_t addr, input data_t data,
			output resp_e resp);
		int cnt;
		@(posedge clk);
		awaddr  <= addr;
		awvalid <= 1'b1;
		wdata   <= data;
		wvalid  <= 1'b1;
		bready  <= 1'b1;
		cnt = 0;
		@(negedge clk);
		while (!(awready && wready) && cnt < TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (!(awready && wready))
			report_timeout(test, "awready and wready");
		// handshake on this edge
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		cnt = 0;
		@(negedge clk);
		while (!bvalid && cnt < TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (!bvalid)
			report_timeout(test, "bvalid");
		resp = bresp;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input string test, input addr_t addr, output data_t data,
			output resp_e resp);
		int cnt;
		@(posedge clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		rready  <= 1'b1;
		cnt = 0;
		@(negedge clk);
		while (!arready && cnt < TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (!arready)
			report_timeout(test, "arready");
		@(posedge clk);
		arvalid <= 1'b0;
		cnt = 0;
		@(negedge clk);
		while (!rvalid && cnt < TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (!rvalid)
			report_timeout(test, "rvalid");
		data = rdata;
		resp = rresp;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	// one frame off the tx line sampled mid bit
	task automatic uart_sample(input string test, output logic [7:0] data,
			output logic start_bit, output logic stop_bit);
		int cnt;
		int i;
		data = '0;
		start_bit = 1'b1;
		stop_bit = 1'b0;
		cnt = 0;
		while (tx !== 1'b0 && cnt < 8 * dut_i.CLKS_PER_BIT) begin
			@(negedge clk);
			cnt++;
		end
		if (tx !== 1'b0) begin
			report_timeout(test, "the start bit on tx");
		end else begin
			repeat (dut_i.CLKS_PER_BIT / 2) @(negedge clk);
			start_bit = tx;
			// lsb first
			for (i = 0; i < 8; i++) begin
				repeat (dut_i.CLKS_PER_BIT) @(negedge clk);
				data[i] = tx;
			end
			repeat (dut_i.CLKS_PER_BIT) @(negedge clk);
			stop_bit = tx;
			// let the stop bit run out
			repeat (dut_i.CLKS_PER_BIT / 2 + 1) @(negedge clk);
		end
	endtask

	task automatic wait_irq(input string test, input logic level);
		int cnt;
		cnt = 0;
		@(negedge clk);
		while (irq !== level && cnt < TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (irq !== level)
			report_timeout(test, level ? "irq to rise" : "irq to fall");
	endtask

	task led_write_readback;
		resp_e resp;
		data_t rd;
		int    base;
		base = errors;
		axi_write("led_basic", reg_addr(LED_SLOT, LED_REG_OFF), 32'hA, resp);
		check_eq("led_basic", "bresp", 32'(RESP_OKAY), 32'(resp));
		check_eq("led_basic", "led", 32'hA, 32'(led));
		axi_read("led_basic", reg_addr(LED_SLOT, LED_REG_OFF), rd, resp);
		check_eq("led_basic", "rresp", 32'(RESP_OKAY), 32'(resp));
		check_eq("led_basic", "readback", 32'hA, rd);
		$display("led_basic done, %0d errors", errors - base);
	endtask

	task led_random_writes;
		resp_e resp;
		data_t rd;
		data_t w;
		int    base;
		int    i;
		base = errors;
		for (i = 0; i < 10; i++) begin
			w = $random(seed);
			axi_write("led_random", reg_addr(LED_SLOT, LED_REG_OFF), w, resp);
			check_eq("led_random", "led", 32'(w[LED_W-1:0]), 32'(led));
			axi_read("led_random", reg_addr(LED_SLOT, LED_REG_OFF), rd, resp);
			check_eq("led_random", "readback", 32'(w[LED_W-1:0]), rd);
		end
		$display("led_random done, %0d errors", errors - base);
	endtask

	task uart_frame_check;
		resp_e      wresp;
		resp_e      resp;
		data_t      rd;
		logic [7:0] byte_rx;
		logic       start_bit;
		logic       stop_bit;
		int         base;
		base = errors;
		// sampler runs alongside the bus traffic
		fork
			uart_sample("uart_frame", byte_rx, start_bit, stop_bit);
			begin
				axi_write("uart_frame", reg_addr(UART_SLOT, UART_TXDATA_OFF), 32'h5A, wresp);
				axi_read("uart_frame", reg_addr(UART_SLOT, UART_STATUS_OFF), rd, resp);
				check_eq("uart_frame", "busy during frame", 32'h1, rd);
			end
		join
		check_eq("uart_frame", "bresp", 32'(RESP_OKAY), 32'(wresp));
		check_eq("uart_frame", "start bit", 32'h0, 32'(start_bit));
		check_eq("uart_frame", "data", 32'h5A, 32'(byte_rx));
		check_eq("uart_frame", "stop bit", 32'h1, 32'(stop_bit));
		axi_read("uart_frame", reg_addr(UART_SLOT, UART_STATUS_OFF), rd, resp);
		check_eq("uart_frame", "busy after frame", 32'h0, rd);
		$display("uart_frame done, %0d errors", errors - base);
	endtask

	task interrupt_sequence;
		resp_e resp;
		data_t rd;
		int    base;
		base = errors;
		// only source 3 enabled
		axi_write("interrupts", reg_addr(INTC_SLOT, INTC_ENABLE_OFF), 32'h08, resp);
		check_eq("interrupts", "enable bresp", 32'(RESP_OKAY), 32'(resp));
		@(posedge clk);
		irq_src <= 8'h28;
		@(posedge clk);
		irq_src <= 8'h00;
		axi_read("interrupts", reg_addr(INTC_SLOT, INTC_PENDING_OFF), rd, resp);
		check_eq("interrupts", "pending", 32'h28, rd);
		wait_irq("interrupts", 1'b1);
		// write one to clear source 3
		axi_write("interrupts", reg_addr(INTC_SLOT, INTC_PENDING_OFF), 32'h08, resp);
		wait_irq("interrupts", 1'b0);
		axi_read("interrupts", reg_addr(INTC_SLOT, INTC_PENDING_OFF), rd, resp);
		check_eq("interrupts", "pending after clear", 32'h20, rd);
		check_eq("interrupts", "irq with bit 5 masked", 32'h0, 32'(irq));
		// raw levels with source 3 kept low
		@(posedge clk);
		irq_src <= 8'hC4;
		axi_read("interrupts", reg_addr(INTC_SLOT, INTC_RAW_OFF), rd, resp);
		check_eq("interrupts", "raw", 32'hC4, rd);
		@(posedge clk);
		irq_src <= 8'h00;
		$display("interrupts done, %0d errors", errors - base);
	endtask

	task unmapped_access;
		resp_e            resp;
		data_t            rd;
		logic [LED_W-1:0] led_before;
		int               base;
		base = errors;
		axi_read("unmapped", reg_addr(4'd5, 12'h000), rd, resp);
		check_eq("unmapped", "rresp", 32'(RESP_SLVERR), 32'(resp));
		check_eq("unmapped", "rdata", 32'h0, rd);
		led_before = led;
		axi_write("unmapped", reg_addr(4'd5, 12'h000), 32'(~led_before), resp);
		check_eq("unmapped", "bresp", 32'(RESP_SLVERR), 32'(resp));
		check_eq("unmapped", "led", 32'(led_before), 32'(led));
		$display("unmapped done, %0d errors", errors - base);
	endtask

	initial begin
		errors  = 0;
		checks  = 0;
		seed    = 67508;
		clk     = 1'b0;
		rst_n   = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		irq_src = '0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		led_write_readback();
		led_random_writes();
		uart_frame_check();
		interrupt_sequence();
		unmapped_access();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: periph_top.sv
`timescale 1ns/1ps
`default_nettype none

module periph_top #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic                      clk,
	input  logic                      rst_n,
	// axi-lite slave port
	input  soc_pkg::addr_t            awaddr,
	input  logic                      awvalid,
	output logic                      awready,
	input  soc_pkg::data_t            wdata,
	input  logic                      wvalid,
	output logic                      wready,
	output soc_pkg::resp_e            bresp,
	output logic                      bvalid,
	input  logic                      bready,
	input  soc_pkg::addr_t            araddr,
	input  logic                      arvalid,
	output logic                      arready,
	output soc_pkg::data_t            rdata,
	output soc_pkg::resp_e            rresp,
	output logic                      rvalid,
	input  logic                      rready,
	// board side
	input  logic [soc_pkg::IRQ_W-1:0] irq_src,
	output logic [soc_pkg::LED_W-1:0] led,
	output logic                      tx,
	output logic                      irq
);
	import soc_pkg::*;

	// apb between bridge and mux
	logic  psel;
	logic  penable;
	logic  pwrite;
	addr_t paddr;
	data_t pwdata;
	data_t prdata;
	logic  pready;
	logic  pslverr;

	// per slave selects and returns
	logic  psel_led;
	logic  psel_uart;
	logic  psel_intc;
	data_t prdata_led;
	data_t prdata_uart;
	data_t prdata_intc;
	logic  pready_led;
	logic  pready_uart;
	logic  pready_intc;

	axi2apb_bridge bridge_i (
		.clk		(clk		),
		.rst_n		(rst_n		),
		.awaddr		(awaddr		),
		.awvalid	(awvalid	),
		.awready	(awready	),
		.wdata		(wdata		),
		.wvalid		(wvalid		),
		.wready		(wready		),
		.bresp		(bresp		),
		.bvalid		(bvalid		),
		.bready		(bready		),
		.araddr		(araddr		),
		.arvalid	(arvalid	),
		.arready	(arready	),
		.rdata		(rdata		),
		.rresp		(rresp		),
		.rvalid		(rvalid		),
		.rready		(rready		),
		.psel		(psel		),
		.penable	(penable	),
		.pwrite		(pwrite		),
		.paddr		(paddr		),
		.pwdata		(pwdata		),
		.prdata		(prdata		),
		.pready		(pready		),
		.pslverr	(pslverr	)
	);

	apb_mux mux_i (
		.psel			(psel			),
		.penable		(penable		),
		.paddr			(paddr			),
		.prdata_led		(prdata_led		),
		.prdata_uart	(prdata_uart	),
		.prdata_intc	(prdata_intc	),
		.pready_led		(pready_led		),
		.pready_uart	(pready_uart	),
		.pready_intc	(pready_intc	),
		.psel_led		(psel_led		),
		.psel_uart		(psel_uart		),
		.psel_intc		(psel_intc		),
		.prdata			(prdata			),
		.pready			(pready			),
		.pslverr		(pslverr		)
	);

	// slot 0
	led_driver led_i (
		.clk		(clk		),
		.rst_n		(rst_n		),
		.psel		(psel_led	),
		.penable	(penable	),
		.pwrite		(pwrite		),
		.paddr		(paddr		),
		.pwdata		(pwdata		),
		.prdata		(prdata_led	),
		.pready		(pready_led	),
		.led		(led		)
	);

	// slot 1, transmit only
	uart_tx #(
		.CLKS_PER_BIT	(CLKS_PER_BIT	)
	) uart_i (
		.clk		(clk		),
		.rst_n		(rst_n		),
		.psel		(psel_uart	),
		.penable	(penable	),
		.pwrite		(pwrite		),
		.paddr		(paddr		),
		.pwdata		(pwdata		),
		.prdata		(prdata_uart),
		.pready		(pready_uart),
		.tx			(tx			)
	);

	// slot 2
	int_controller intc_i (
		.clk		(clk		),
		.rst_n		(rst_n		),
		.psel		(psel_intc	),
		.penable	(penable	),
		.pwrite		(pwrite		),
		.paddr		(paddr		),
		.pwdata		(pwdata		),
		.irq_src	(irq_src	),
		.prdata		(prdata_intc),
		.pready		(pready_intc),
		.irq		(irq		)
	);

endmodule

`default_nettype wire

// File: int_controller.sv
`timescale 1ns/1ps
`default_nettype none

module int_controller (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  soc_pkg::addr_t            paddr,
	input  soc_pkg::data_t            pwdata,
	input  logic [soc_pkg::IRQ_W-1:0] irq_src,
	output soc_pkg::data_t            prdata,
	output logic                      pready,
	output logic                      irq
);
	import soc_pkg::*;

	logic [IRQ_W-1:0] enable_q;
	logic [IRQ_W-1:0] pending_q;
	logic [IRQ_W-1:0] clr;
	logic             wr_en;
	logic             irq_q;
	logic [11:0]      off;

	assign off   = paddr[11:0];
	assign wr_en = psel && penable && pwrite;

	// write one to clear pending
	assign clr = (wr_en && off == INTC_PENDING_OFF) ? pwdata[IRQ_W-1:0] : '0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			enable_q  <= '0;
			pending_q <= '0;
			irq_q     <= 1'b0;
		end else begin
			if (wr_en && off == INTC_ENABLE_OFF)
				enable_q <= pwdata[IRQ_W-1:0];
			// a live source beats a clear in the same cycle
			pending_q <= (pending_q & ~clr) | irq_src;
			// registered, one cycle behind pending and enable
			irq_q <= |(pending_q & enable_q);
		end
	end

	assign irq = irq_q;

	// readback, raw shows the sources as they are now
	always_comb begin
		case (off)
			INTC_ENABLE_OFF: prdata = data_t'(enable_q);
			INTC_PENDING_OFF: prdata = data_t'(pending_q);
			INTC_RAW_OFF: prdata = data_t'(irq_src);
			default: prdata = '0;
		endcase
	end

	// completes in the access cycle
	assign pready = psel && penable;

endmodule

`default_nettype wire

// File: uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            psel,
	input  logic            penable,
	input  logic            pwrite,
	input  soc_pkg::addr_t  paddr,
	input  soc_pkg::data_t  pwdata,
	output soc_pkg::data_t  prdata,
	output logic            pready,
	output logic            tx
);
	import soc_pkg::*;

	localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

	uart_state_e      state_q;
	logic [CNT_W-1:0] cnt_q;
	logic [2:0]       bit_q;
	logic [7:0]       shift_q;
	logic             tx_q;
	logic             busy;
	logic             bit_end;
	logic             wr_data;

	assign busy    = (state_q != TX_IDLE);
	assign bit_end = (cnt_q == CNT_W'(CLKS_PER_BIT - 1));
	assign wr_data = psel && penable && pwrite && (paddr[11:0] == UART_TXDATA_OFF);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= TX_IDLE;
			cnt_q   <= '0;
			bit_q   <= '0;
			tx_q    <= 1'b1;
		end else begin
			// bit period counter
			cnt_q <= (state_q == TX_IDLE || bit_end) ? '0 : cnt_q + 1'b1;
			case (state_q)
				// writes while busy fall through here unseen
				TX_IDLE: if (wr_data) begin
					state_q <= TX_START;
					tx_q    <= 1'b0;
				end
				TX_START: if (bit_end) begin
					state_q <= TX_DATA;
					bit_q   <= '0;
					tx_q    <= shift_q[0];
				end
				// lsb first
				TX_DATA: if (bit_end) begin
					if (bit_q == 3'd7) begin
						state_q <= TX_STOP;
						tx_q    <= 1'b1;
					end else begin
						bit_q <= bit_q + 1'b1;
						tx_q  <= shift_q[1];
					end
				end
				TX_STOP: if (bit_end) state_q <= TX_IDLE;
				default: state_q <= TX_IDLE;
			endcase
		end
	end

	// data byte, loaded on accepted write, shifted per data bit
	always_ff @(posedge clk) begin
		if (state_q == TX_IDLE && wr_data)
			shift_q <= pwdata[7:0];
		else if (state_q == TX_DATA && bit_end)
			shift_q <= shift_q >> 1;
	end

	assign tx = tx_q;

	// status bit 0 is busy, txdata reads zero
	assign prdata = (paddr[11:0] == UART_STATUS_OFF) ? data_t'(busy) : '0;
	assign pready = psel && penable;

	// line idles high between frames and through the stop bit
	assert property (@(posedge clk) disable iff (!rst_n)
		(state_q == TX_IDLE || state_q == TX_STOP) |-> tx)
		else $error("uart_tx: tx low outside start or data bits");

endmodule

`default_nettype wire

// File: led_driver.sv
`timescale 1ns/1ps
`default_nettype none

module led_driver (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  soc_pkg::addr_t            paddr,
	input  soc_pkg::data_t            pwdata,
	output soc_pkg::data_t            prdata,
	output logic                      pready,
	output logic [soc_pkg::LED_W-1:0] led
);
	import soc_pkg::*;

	logic [LED_W-1:0] led_q;
	logic             hit;
	logic             wr_en;

	// single register at offset 0
	assign hit   = (paddr[11:0] == LED_REG_OFF);
	assign wr_en = psel && penable && pwrite && hit;

	// led value, updates at end of the access cycle
	always_ff @(posedge clk) begin
		if (!rst_n)
			led_q <= '0;
		else if (wr_en)
			led_q <= pwdata[LED_W-1:0];
	end

	assign led = led_q;

	// zero extended readback
	assign prdata = hit ? data_t'(led_q) : '0;

	// no wait states
	assign pready = psel && penable;

endmodule

`default_nettype wire

// File: apb_mux.sv
`timescale 1ns/1ps
`default_nettype none

module apb_mux (
	input  logic            psel,
	input  logic            penable,
	input  soc_pkg::addr_t  paddr,
	input  soc_pkg::data_t  prdata_led,
	input  soc_pkg::data_t  prdata_uart,
	input  soc_pkg::data_t  prdata_intc,
	input  logic            pready_led,
	input  logic            pready_uart,
	input  logic            pready_intc,
	output logic            psel_led,
	output logic            psel_uart,
	output logic            psel_intc,
	output soc_pkg::data_t  prdata,
	output logic            pready,
	output logic            pslverr
);
	import soc_pkg::*;

	logic [3:0] slot;
	logic       mapped;

	// slot field of the window
	assign slot = paddr[15:12];

	assign psel_led  = psel && (slot == LED_SLOT);
	assign psel_uart = psel && (slot == UART_SLOT);
	assign psel_intc = psel && (slot == INTC_SLOT);

	// return path, unmapped slot answers at once with zero data
	always_comb begin
		prdata = '0;
		pready = 1'b1;
		mapped = 1'b1;
		case (slot)
			LED_SLOT: begin
				prdata = prdata_led;
				pready = pready_led;
			end
			UART_SLOT: begin
				prdata = prdata_uart;
				pready = pready_uart;
			end
			INTC_SLOT: begin
				prdata = prdata_intc;
				pready = pready_intc;
			end
			default: mapped = 1'b0;
		endcase
	end

	// error only meaningful in the access cycle
	assign pslverr = psel && penable && !mapped;

	// slave selects are exclusive
	always_comb begin
		assert final ($onehot0({psel_led, psel_uart, psel_intc}))
			else $error("apb_mux: more than one slave selected");
	end

endmodule

`default_nettype wire

// File: axi2apb_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module axi2apb_bridge (
	input  logic            clk,
	input  logic            rst_n,
	// axi write address
	input  soc_pkg::addr_t  awaddr,
	input  logic            awvalid,
	output logic            awready,
	// axi write data
	input  soc_pkg::data_t  wdata,
	input  logic            wvalid,
	output logic            wready,
	// axi write response
	output soc_pkg::resp_e  bresp,
	output logic            bvalid,
	input  logic            bready,
	// axi read address
	input  soc_pkg::addr_t  araddr,
	input  logic            arvalid,
	output logic            arready,
	// axi read data
	output soc_pkg::data_t  rdata,
	output soc_pkg::resp_e  rresp,
	output logic            rvalid,
	input  logic            rready,
	// apb master side
	output logic            psel,
	output logic            penable,
	output logic            pwrite,
	output soc_pkg::addr_t  paddr,
	output soc_pkg::data_t  pwdata,
	input  soc_pkg::data_t  prdata,
	input  logic            pready,
	input  logic            pslverr
);
	import soc_pkg::*;

	bridge_state_e state_q;
	bridge_state_e state_d;
	logic          aw_hs;
	logic          ar_hs;
	logic          write_q;
	addr_t         addr_q;
	data_t         wdata_q;
	data_t         rdata_q;
	resp_e         resp_q;

	// aw and w accepted together, write wins a tie with ar
	assign awready = (state_q == BR_IDLE) && awvalid && wvalid;
	assign wready  = awready;
	assign arready = (state_q == BR_IDLE) && !(awvalid && wvalid);
	assign aw_hs   = awvalid && awready;
	assign ar_hs   = arvalid && arready;

	always_comb begin
		state_d = state_q;
		case (state_q)
			BR_IDLE: if (aw_hs || ar_hs) state_d = BR_SETUP;
			BR_SETUP: state_d = BR_ACCESS;
			// every slave finishes here, pready kept for protocol
			BR_ACCESS: if (pready) state_d = write_q ? BR_WRESP : BR_RRESP;
			BR_WRESP: if (bready) state_d = BR_IDLE;
			BR_RRESP: if (rready) state_d = BR_IDLE;
			default: state_d = BR_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= BR_IDLE;
			write_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (aw_hs)
				write_q <= 1'b1;
			else if (ar_hs)
				write_q <= 1'b0;
		end
	end

	// request and response payload
	always_ff @(posedge clk) begin
		if (aw_hs) begin
			addr_q  <= awaddr;
			wdata_q <= wdata;
		end else if (ar_hs) begin
			addr_q <= araddr;
		end
		if (state_q == BR_ACCESS && pready) begin
			resp_q <= pslverr ? RESP_SLVERR : RESP_OKAY;
			if (!write_q)
				rdata_q <= prdata;
		end
	end

	// apb side decoded from state
	assign psel    = (state_q == BR_SETUP) || (state_q == BR_ACCESS);
	assign penable = (state_q == BR_ACCESS);
	assign pwrite  = write_q;
	assign paddr   = addr_q;
	assign pwdata  = wdata_q;

	// axi responses
	assign bvalid = (state_q == BR_WRESP);
	assign bresp  = resp_q;
	assign rvalid = (state_q == BR_RRESP);
	assign rresp  = resp_q;
	assign rdata  = rdata_q;

	// access always preceded by a selected cycle, setup or stalled access
	assert property (@(posedge clk) disable iff (!rst_n) penable |-> psel && $past(psel))
		else $error("axi2apb_bridge: penable without setup");

	// one transfer in flight, so never both responses
	assert property (@(posedge clk) disable iff (!rst_n) !(bvalid && rvalid))
		else $error("axi2apb_bridge: bvalid and rvalid together");

endmodule

`default_nettype wire

// File: soc_pkg.sv
`default_nettype none

package soc_pkg;

	// bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;

	// axi response codes, only the two this port can return
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_e;

	// peripheral window, slot number sits in addr[15:12]
	localparam addr_t APB_BASE = 32'h1fe0_0000;

	localparam logic [3:0] LED_SLOT  = 4'd0;
	localparam logic [3:0] UART_SLOT = 4'd1;
	localparam logic [3:0] INTC_SLOT = 4'd2;

	// register offsets inside a slot, addr[11:0]
	localparam logic [11:0] LED_REG_OFF      = 12'h000;
	localparam logic [11:0] UART_TXDATA_OFF  = 12'h000;
	localparam logic [11:0] UART_STATUS_OFF  = 12'h004;
	localparam logic [11:0] INTC_ENABLE_OFF  = 12'h000;
	localparam logic [11:0] INTC_PENDING_OFF = 12'h004;
	localparam logic [11:0] INTC_RAW_OFF     = 12'h008;

	// board leds
	localparam int LED_W = 4;
	// timer, i2c, uart1, uart0, flash, spi, vpwm, dma
	localparam int IRQ_W = 8;

	// axi to apb bridge
	typedef enum logic [2:0] {
		BR_IDLE,
		BR_SETUP,
		BR_ACCESS,
		BR_WRESP,
		BR_RRESP
	} bridge_state_e;

	// uart transmitter
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} uart_state_e;

endpackage

`default_nettype wire
